// File: design/matrix_pkg.sv
package matrix_pkg;

  // ------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------

  // Largest row or column count of an operand
  localparam int MAX_DIM = 4;
  // Dimension and index width, holds 0 to MAX_DIM
  localparam int DIM_W   = 3;
  // Signed operand element
  localparam int ELEM_W  = 8;
  // Full precision result, no saturation anywhere
  localparam int RES_W   = 32;
  // Busy cycle counter width
  localparam int CNT_W   = 32;

  typedef logic [DIM_W-1:0]         dim_t;
  typedef logic signed [ELEM_W-1:0] elem_data_t;
  typedef logic signed [RES_W-1:0]  res_t;

  typedef enum logic [1:0] {
    OP_ADD        = 2'd0,
    OP_SCALAR_MUL = 2'd1,
    OP_TRANSPOSE  = 2'd2,
    OP_MAT_MUL    = 2'd3
  } op_code_t;

  // Operand matrix, cells[row][col] in row-major order
  typedef struct packed {
    dim_t                                      rows;
    dim_t                                      cols;
    elem_data_t [MAX_DIM-1:0][MAX_DIM-1:0]     cells;
  } matrix_t;

  // ------------------------------------------------------------------
  // Pipeline stage payloads
  // ------------------------------------------------------------------

  // One issued term of one output element
  typedef struct packed {
    logic     valid;
    op_code_t op;
    dim_t     i;
    dim_t     j;
    dim_t     k;
    logic     first_term;
    logic     last_term;
    logic     last_col;
  } term_req_t;

  // One fetched term, operands already sign extended
  typedef struct packed {
    logic valid;
    // High selects a + b, low selects a * b
    logic use_sum;
    res_t a;
    res_t b;
    logic first_term;
    logic last_term;
    logic last_col;
  } operand_t;

  // One finished result element
  typedef struct packed {
    logic valid;
    res_t data;
    logic last_col;
  } elem_t;

endpackage

// File: design/matrix_seq.sv
`timescale 1ns/1ps

module matrix_seq import matrix_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  op_code_t         op_i,
  input  dim_t             dims_a_rows_i,
  input  dim_t             dims_a_cols_i,
  input  dim_t             dims_b_rows_i,
  input  dim_t             dims_b_cols_i,
  input  logic             elem_accepted_i,
  output term_req_t        term_o,
  output logic             done_o,
  output logic             error_flag_o,
  output logic [CNT_W-1:0] cycle_cnt_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_WAIT,
    S_DONE
  } seq_state_t;

  seq_state_t       state_q;
  op_code_t         op_q;
  dim_t             i_q;
  dim_t             j_q;
  dim_t             k_q;
  dim_t             lim_i_q;
  dim_t             lim_j_q;
  dim_t             lim_k_q;
  dim_t             lim_i_d;
  dim_t             lim_j_d;
  dim_t             lim_k_d;
  logic             done_q;
  logic             err_q;
  logic [CNT_W-1:0] cnt_q;
  logic             dims_in_range;
  logic             shape_ok;
  logic             start_ok;
  logic             i_last;
  logic             j_last;
  logic             k_last;

  // Dimension must be 1..MAX_DIM
  function automatic logic dim_valid(input dim_t d);
    return (d != '0) && (d <= DIM_W'(MAX_DIM));
  endfunction

  // ------------------------------------------------------------------
  // Start check and loop limits
  // ------------------------------------------------------------------

  assign dims_in_range = dim_valid(dims_a_rows_i) && dim_valid(dims_a_cols_i) &&
                         dim_valid(dims_b_rows_i) && dim_valid(dims_b_cols_i);

  always_comb begin
    // Element-wise shape by default, one term per element
    shape_ok = 1'b1;
    lim_i_d  = dims_a_rows_i;
    lim_j_d  = dims_a_cols_i;
    lim_k_d  = DIM_W'(1);
    case (op_i)
      OP_ADD: begin
        shape_ok = (dims_a_rows_i == dims_b_rows_i) && (dims_a_cols_i == dims_b_cols_i);
      end
      OP_TRANSPOSE: begin
        // Output is A.cols x A.rows
        lim_i_d = dims_a_cols_i;
        lim_j_d = dims_a_rows_i;
      end
      OP_MAT_MUL: begin
        // Inner dimension becomes the term count
        shape_ok = (dims_a_cols_i == dims_b_rows_i);
        lim_j_d  = dims_b_cols_i;
        lim_k_d  = dims_a_cols_i;
      end
      default: begin
        shape_ok = 1'b1;
      end
    endcase
  end

  assign start_ok = dims_in_range && shape_ok;

  // Position flags inside the current walk
  assign i_last = (i_q == lim_i_q - DIM_W'(1));
  assign j_last = (j_q == lim_j_q - DIM_W'(1));
  assign k_last = (k_q == lim_k_q - DIM_W'(1));

  // Term issued every cycle spent in S_ISSUE
  always_comb begin
    term_o.valid      = (state_q == S_ISSUE);
    term_o.op         = op_q;
    term_o.i          = i_q;
    term_o.j          = j_q;
    term_o.k          = k_q;
    term_o.first_term = (k_q == '0);
    term_o.last_term  = k_last;
    term_o.last_col   = j_last;
  end

  // ------------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      op_q    <= OP_ADD;
      i_q     <= '0;
      j_q     <= '0;
      k_q     <= '0;
      lim_i_q <= '0;
      lim_j_q <= '0;
      lim_k_q <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            op_q    <= op_i;
            i_q     <= '0;
            j_q     <= '0;
            k_q     <= '0;
            lim_i_q <= lim_i_d;
            lim_j_q <= lim_j_d;
            lim_k_q <= lim_k_d;
            cnt_q   <= '0;
            if (start_ok) begin
              err_q   <= 1'b0;
              state_q <= S_ISSUE;
            end else begin
              // Bad shape ends at once with nothing streamed
              err_q   <= 1'b1;
              done_q  <= 1'b1;
              state_q <= S_DONE;
            end
          end
        end
        S_ISSUE: begin
          cnt_q <= cnt_q + 1'b1;
          if (k_last) begin
            k_q     <= '0;
            state_q <= S_WAIT;
          end else begin
            k_q <= k_q + 1'b1;
          end
        end
        S_WAIT: begin
          cnt_q <= cnt_q + 1'b1;
          // Next element only after the previous one left the stream
          if (elem_accepted_i) begin
            if (i_last && j_last) begin
              done_q  <= 1'b1;
              state_q <= S_DONE;
            end else if (j_last) begin
              j_q     <= '0;
              i_q     <= i_q + 1'b1;
              state_q <= S_ISSUE;
            end else begin
              j_q     <= j_q + 1'b1;
              state_q <= S_ISSUE;
            end
          end
        end
        S_DONE: begin
          // Hold done until start is released
          if (!start_i) begin
            done_q  <= 1'b0;
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  assign done_o       = done_q;
  assign error_flag_o = err_q;
  assign cycle_cnt_o  = cnt_q;

endmodule

// File: design/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch import matrix_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  term_req_t  term_i,
  input  matrix_t    matrix_a_i,
  input  matrix_t    matrix_b_i,
  input  elem_data_t scalar_i,
  output operand_t   opnd_o
);

  elem_data_t a_sel;
  elem_data_t b_sel;
  logic       use_sum;
  operand_t   opnd_q;

  function automatic res_t sext(input elem_data_t v);
    return RES_W'(v);
  endfunction

  // Operand select per operation
  always_comb begin
    use_sum = 1'b0;
    a_sel   = matrix_a_i.cells[term_i.i][term_i.j];
    b_sel   = matrix_b_i.cells[term_i.i][term_i.j];
    case (term_i.op)
      OP_ADD: begin
        use_sum = 1'b1;
      end
      OP_SCALAR_MUL: begin
        b_sel = scalar_i;
      end
      OP_TRANSPOSE: begin
        // Swapped indices, times one through the multiplier
        a_sel = matrix_a_i.cells[term_i.j][term_i.i];
        b_sel = ELEM_W'(1);
      end
      OP_MAT_MUL: begin
        a_sel = matrix_a_i.cells[term_i.i][term_i.k];
        b_sel = matrix_b_i.cells[term_i.k][term_i.j];
      end
      default: begin
        use_sum = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opnd_q <= '0;
    end else begin
      // Valid follows every issue cycle
      opnd_q.valid <= term_i.valid;
      // Payload only moves with a valid term
      if (term_i.valid) begin
        opnd_q.use_sum    <= use_sum;
        opnd_q.a          <= sext(a_sel);
        opnd_q.b          <= sext(b_sel);
        opnd_q.first_term <= term_i.first_term;
        opnd_q.last_term  <= term_i.last_term;
        opnd_q.last_col   <= term_i.last_col;
      end
    end
  end

  assign opnd_o = opnd_q;

endmodule

// File: design/mac_stage.sv
`timescale 1ns/1ps

module mac_stage import matrix_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  operand_t opnd_i,
  output elem_t    elem_o
);

  res_t prod;
  res_t add_x;
  res_t add_y;
  res_t add_sum;
  res_t acc_q;
  logic valid_q;
  logic last_col_q;

  // ------------------------------------------------------------------
  // Shared datapath
  // ------------------------------------------------------------------

  // Single multiplier, low RES_W bits of the signed product
  assign prod = opnd_i.a * opnd_i.b;

  // Single adder
  // sum mode gives a + b, product mode gives product plus running total
  assign add_x = opnd_i.use_sum ? opnd_i.a : prod;

  always_comb begin
    if (opnd_i.use_sum) begin
      add_y = opnd_i.b;
    end else if (opnd_i.first_term) begin
      // Restart the dot product
      add_y = '0;
    end else begin
      add_y = acc_q;
    end
  end

  assign add_sum = add_x + add_y;

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------

  // One-cycle pulse when the final term of an element lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= opnd_i.valid & opnd_i.last_term;
    end
  end

  // Accumulator doubles as the element data register
  always_ff @(posedge clk) begin
    if (opnd_i.valid) begin
      acc_q      <= add_sum;
      last_col_q <= opnd_i.last_col;
    end
  end

  assign elem_o.valid    = valid_q;
  assign elem_o.data     = acc_q;
  assign elem_o.last_col = last_col_q;

endmodule

// File: design/stream_out.sv
`timescale 1ns/1ps

module stream_out import matrix_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  elem_t elem_i,
  input  logic  stream_ready_i,
  output logic  stream_valid_o,
  output res_t  stream_data_o,
  output logic  stream_last_col_o,
  output logic  elem_accepted_o
);

  logic valid_q;
  res_t data_q;
  logic last_col_q;
  logic handshake;

  // Element moves when valid meets ready
  assign handshake = valid_q & stream_ready_i;

  // Sequencer waits for acceptance, so a new element never
  // lands on top of one still held here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (elem_i.valid) begin
      valid_q <= 1'b1;
    end else if (handshake) begin
      valid_q <= 1'b0;
    end
  end

  // Data held stable under back-pressure
  always_ff @(posedge clk) begin
    if (elem_i.valid) begin
      data_q     <= elem_i.data;
      last_col_q <= elem_i.last_col;
    end
  end

  assign stream_valid_o    = valid_q;
  assign stream_data_o     = data_q;
  assign stream_last_col_o = last_col_q;
  assign elem_accepted_o   = handshake;

endmodule

// File: design/matrix_alu_top.sv
`timescale 1ns/1ps

module matrix_alu_top import matrix_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  op_code_t         op_i,
  input  matrix_t          matrix_a_i,
  input  matrix_t          matrix_b_i,
  input  elem_data_t       scalar_i,
  input  logic             stream_ready_i,
  output logic             done_o,
  output logic             error_flag_o,
  output logic [CNT_W-1:0] cycle_cnt_o,
  output logic             stream_valid_o,
  output res_t             stream_data_o,
  output logic             stream_last_col_o
);

  // Stage to stage payloads
  term_req_t term;
  operand_t  opnd;
  elem_t     elem;
  logic      elem_accepted;

  // ------------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------------

  matrix_seq u_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .op_i            (op_i),
    .dims_a_rows_i   (matrix_a_i.rows),
    .dims_a_cols_i   (matrix_a_i.cols),
    .dims_b_rows_i   (matrix_b_i.rows),
    .dims_b_cols_i   (matrix_b_i.cols),
    .elem_accepted_i (elem_accepted),
    .term_o          (term),
    .done_o          (done_o),
    .error_flag_o    (error_flag_o),
    .cycle_cnt_o     (cycle_cnt_o)
  );

  operand_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .term_i     (term),
    .matrix_a_i (matrix_a_i),
    .matrix_b_i (matrix_b_i),
    .scalar_i   (scalar_i),
    .opnd_o     (opnd)
  );

  mac_stage u_mac (
    .clk    (clk),
    .rst_n  (rst_n),
    .opnd_i (opnd),
    .elem_o (elem)
  );

  // Output holding register and handshake
  stream_out u_out (
    .clk               (clk),
    .rst_n             (rst_n),
    .elem_i            (elem),
    .stream_ready_i    (stream_ready_i),
    .stream_valid_o    (stream_valid_o),
    .stream_data_o     (stream_data_o),
    .stream_last_col_o (stream_last_col_o),
    .elem_accepted_o   (elem_accepted)
  );

endmodule

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model of the matrix unit
// ----------------------------------------------------------------------

// Dimension legal range is 1..MAX_DIM
function automatic bit dim_out_of_range(input dim_t d);
  return (int'(d) < 1) || (int'(d) > MAX_DIM);
endfunction

// Start rejected on any bad dimension or shape
function automatic bit expect_error(input op_code_t op, input matrix_t a, input matrix_t b);
  if (dim_out_of_range(a.rows) || dim_out_of_range(a.cols) ||
      dim_out_of_range(b.rows) || dim_out_of_range(b.cols)) begin
    return 1'b1;
  end
  if (op == OP_ADD) begin
    return (a.rows != b.rows) || (a.cols != b.cols);
  end
  if (op == OP_MAT_MUL) begin
    return a.cols != b.rows;
  end
  return 1'b0;
endfunction

// Output shape
function automatic int result_rows(input op_code_t op, input matrix_t a);
  return (op == OP_TRANSPOSE) ? int'(a.cols) : int'(a.rows);
endfunction

function automatic int result_cols(input op_code_t op, input matrix_t a, input matrix_t b);
  case (op)
    OP_TRANSPOSE: return int'(a.rows);
    OP_MAT_MUL:   return int'(b.cols);
    default:      return int'(a.cols);
  endcase
endfunction

// Dot product length for multiply, one otherwise
function automatic int terms_per_element(input op_code_t op, input matrix_t a);
  return (op == OP_MAT_MUL) ? int'(a.cols) : 1;
endfunction

// Full precision value of output element (i, j)
function automatic int expected_element(input op_code_t op, input matrix_t a,
                                        input matrix_t b, input elem_data_t s,
                                        input int i, input int j);
  int sum;
  sum = 0;
  case (op)
    OP_ADD:        sum = int'(a.cells[i][j]) + int'(b.cells[i][j]);
    OP_SCALAR_MUL: sum = int'(a.cells[i][j]) * int'(s);
    OP_TRANSPOSE:  sum = int'(a.cells[j][i]);
    default: begin
      for (int k = 0; k < int'(a.cols); k++) begin
        sum += int'(a.cells[i][k]) * int'(b.cells[k][j]);
      end
    end
  endcase
  return sum;
endfunction

`endif

// File: tests/tb_matrix_alu.sv
`timescale 1ns/1ps

module tb_matrix_alu import matrix_pkg::*; ();

  localparam int NUM_TESTS      = 200;
  localparam int CYCLES_PER_RUN = 400;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * CYCLES_PER_RUN;

  logic             clk;
  logic             rst_n;
  logic             start_i;
  op_code_t         op_i;
  matrix_t          matrix_a_i;
  matrix_t          matrix_b_i;
  elem_data_t       scalar_i;
  logic             stream_ready_i;
  logic             done_o;
  logic             error_flag_o;
  logic [CNT_W-1:0] cycle_cnt_o;
  logic             stream_valid_o;
  res_t             stream_data_o;
  logic             stream_last_col_o;

  logic [31:0] lcg_state   = 32'hfd01;
  int          cycle_count = 0;

  `include "tb_model.svh"

  matrix_alu_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .start_i           (start_i),
    .op_i              (op_i),
    .matrix_a_i        (matrix_a_i),
    .matrix_b_i        (matrix_b_i),
    .scalar_i          (scalar_i),
    .stream_ready_i    (stream_ready_i),
    .done_o            (done_o),
    .error_flag_o      (error_flag_o),
    .cycle_cnt_o       (cycle_cnt_o),
    .stream_valid_o    (stream_valid_o),
    .stream_data_o     (stream_data_o),
    .stream_last_col_o (stream_last_col_o)
  );

  // ----------------------------------------------------------------------
  // Clock, timeout and helpers
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycle_count);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Upper bits only, low LCG bits repeat quickly
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  function automatic dim_t random_dim();
    return dim_t'(1 + next_random() % MAX_DIM);
  endfunction

  // Four-state compare so unknown DUT bits never pass
  task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      $display("** FAIL **");
      $fatal(1, "Mismatch against the model");
    end
  endtask

  // ----------------------------------------------------------------------
  // One operation from start to done
  // ----------------------------------------------------------------------

  task automatic run_test();
    matrix_t    a;
    matrix_t    b;
    op_code_t   op_sel;
    elem_data_t s;
    bit         exp_err;
    bit         done_seen;
    bit         held;
    res_t       held_data;
    logic       held_last;
    int         cols;
    int         exp_count;
    int         terms;
    int         count;
    int         cnt_at_done;
    op_sel = op_code_t'(next_random() % 4);
    a.rows = random_dim();
    a.cols = random_dim();
    b.rows = (op_sel == OP_ADD) ? a.rows : (op_sel == OP_MAT_MUL) ? a.cols : random_dim();
    b.cols = (op_sel == OP_ADD) ? a.cols : random_dim();
    for (int r = 0; r < MAX_DIM; r++) begin
      for (int c = 0; c < MAX_DIM; c++) begin
        a.cells[r][c] = elem_data_t'(next_random());
        b.cells[r][c] = elem_data_t'(next_random());
      end
    end
    s = elem_data_t'(next_random());
    // Occasional bad shape or out of range dimension
    if (next_random() % 8 == 0) begin
      case (next_random() % 3)
        0:       b.rows = dim_t'(int'(b.rows) % MAX_DIM + 1);
        1:       a.cols = '0;
        default: b.cols = dim_t'(5 + next_random() % 3);
      endcase
    end
    exp_err   = expect_error(op_sel, a, b);
    cols      = exp_err ? 1 : result_cols(op_sel, a, b);
    exp_count = exp_err ? 0 : result_rows(op_sel, a) * cols;
    terms     = exp_count * terms_per_element(op_sel, a);
    start_i    <= 1'b1;
    op_i       <= op_sel;
    matrix_a_i <= a;
    matrix_b_i <= b;
    scalar_i   <= s;
    count     = 0;
    held      = 1'b0;
    done_seen = 1'b0;
    while (!done_seen) begin
      @(posedge clk);
      // Back-pressure must freeze the output
      if (held) begin
        check_value(stream_valid_o, 1, "valid dropped while waiting");
        check_value(stream_data_o, held_data, "data changed while waiting");
        check_value(stream_last_col_o, held_last, "last_col changed while waiting");
      end
      if (stream_valid_o && stream_ready_i) begin
        check_value(count < exp_count, 1, "element beyond expected count");
        check_value(stream_data_o,
                    expected_element(op_sel, a, b, s, count / cols, count % cols),
                    "element data");
        check_value(stream_last_col_o, (count % cols) == cols - 1, "last_col flag");
        count++;
      end
      held      = stream_valid_o && !stream_ready_i;
      held_data = stream_data_o;
      held_last = stream_last_col_o;
      done_seen = done_o;
      stream_ready_i <= (next_random() % 4) != 0;
    end
    check_value(error_flag_o, exp_err, "error flag");
    check_value(count, exp_count, "element count");
    check_value(stream_valid_o, 0, "stream valid after done");
    if (!exp_err) begin
      check_value(cycle_cnt_o >= terms, 1, "busy count below term count");
    end
    cnt_at_done = cycle_cnt_o;
    // Done level held while start stays high
    @(posedge clk);
    check_value(done_o, 1, "done fell with start high");
    check_value(cycle_cnt_o, cnt_at_done, "busy count moved after done");
    start_i <= 1'b0;
    while (done_o) begin
      @(posedge clk);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_n          = 1'b0;
    start_i        = 1'b0;
    op_i           = OP_ADD;
    matrix_a_i     = '0;
    matrix_b_i     = '0;
    scalar_i       = '0;
    stream_ready_i = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Idle outputs out of reset
    check_value(done_o, 0, "done after reset");
    check_value(error_flag_o, 0, "error flag after reset");
    check_value(stream_valid_o, 0, "stream valid after reset");
    check_value(cycle_cnt_o, 0, "busy count after reset");
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test();
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: flist.f
+incdir+tests
design/matrix_pkg.sv
design/matrix_seq.sv
design/operand_fetch.sv
design/mac_stage.sv
design/stream_out.sv
design/matrix_alu_top.sv
tests/tb_matrix_alu.sv
